// File: build.f
+incdir+src
src/rffe_cmd_pkg.sv
src/rffe_bus_pkg.sv
src/rffe_sclk_gen.sv
src/rffe_field_shifter.sv
src/rffe_frame_ctrl.sv
src/rffe_master_top.sv
testbench/tb_clk_gen.sv
testbench/rffe_sva.sv
testbench/tb_rffe.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rffe
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "test did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_rffe.sv
// testbench top: random host commands, bus slave model, checks and reporting
`include "rffe_consts.svh"

module tb_rffe;

   localparam int     CLK_DIV   = `RFFE_CLK_DIV_DEF;
   localparam int     NUM_TESTS = 40;
   localparam longint WATCHDOG  = longint'(NUM_TESTS) * 60 * 2 * CLK_DIV * 8;

   logic                    clk;
   logic                    rst;
   logic                    i_req;
   rffe_cmd_pkg::rffe_cmd_t i_cmd;
   logic                    o_ack;
   rffe_cmd_pkg::rffe_rsp_t o_rsp;
   logic                    i_sdata;
   logic                    o_sclk;
   logic                    o_sdata;
   logic                    o_sdata_en;

   logic [7:0] mem [256];     // slave register file
   logic       bad_par;       // slave corrupts one read parity bit
   int         bad_idx;
   logic       drv;           // slave driving sdata
   logic       ack_q;
   int         frames;
   int         sclk_falls;    // sclk cycles seen on the bus
   logic [3:0] s_sa;
   logic [7:0] s_cmd;
   logic [7:0] s_addr;
   logic [7:0] s_data [4];
   int         s_nbytes;
   logic       s_par_ok;
   int         ssc_err;
   int         hs_err;
   int         test_err;
   int         pass_cnt;
   int         fail_cnt;
   string      tname;

   tb_clk_gen clk_gen_i (.o_clk(clk), .o_rst(rst));

   rffe_master_top #(.CLK_DIV(CLK_DIV)) dut_i (
      .clk(clk), .i_rst(rst), .i_req(i_req), .i_cmd(i_cmd), .o_ack(o_ack), .o_rsp(o_rsp),
      .i_sdata(i_sdata), .o_sclk(o_sclk), .o_sdata(o_sdata), .o_sdata_en(o_sdata_en)
   );

   ////////////////////
   // slave model

   task automatic get_bits(input int n, output logic [8:0] v);
      v = '0;
      repeat (n) begin
         @(negedge o_sclk);
         if (!o_sdata_en) begin
            $display("master was not driving sdata during a bit it sent");
            hs_err++;
         end
         v = {v[7:0], o_sdata};
      end
   endtask

   task automatic send_bytes(input int n, input logic [7:0] a);
      logic [8:0] w;
      @(negedge o_sclk);                          // park bit
      for (int i = 0; i < n; i++) begin
         w = {mem[8'(a + i)], ~^mem[8'(a + i)]};  // odd parity
         if (bad_par && i == bad_idx) w[0] = ~w[0];
         for (int b = 8; b >= 0; b--) begin
            @(posedge o_sclk);
            i_sdata <= w[b];
            drv     <= 1'b1;
         end
      end
      @(posedge o_sclk);                          // end bit, hand line back
      i_sdata <= 1'b0;
      drv     <= 1'b0;
   endtask

   initial begin
      logic [8:0] v;
      int         n;
      i_sdata    = 1'b0;
      drv        = 1'b0;
      frames     = 0;
      sclk_falls = 0;
      ssc_err    = 0;
      forever begin
         @(posedge o_sdata);                      // ssc high bit
         if (o_ack) begin
            $display("sequence start seen while ack was high");
            ssc_err++;
         end
         s_nbytes = 0;
         s_addr   = '0;
         get_bits(4, v);
         s_sa = v[3:0];
         get_bits(9, v);
         s_cmd    = v[8:1];
         s_par_ok = ($countones({s_sa, v}) % 2) == 1;  // sa and cmd share parity
         n = (s_cmd[7:4] == 4'b0000 || s_cmd[7:4] == 4'b0010) ? s_cmd[1:0] + 1 : 1;
         if (s_cmd[7:4] == 4'b0000 || s_cmd[7:4] == 4'b0010) begin
            get_bits(9, v);
            s_addr = v[8:1];
            if ($countones(v) % 2 == 0) s_par_ok = 1'b0;
         end
         if (s_cmd[7:5] == 3'b011) begin
            send_bytes(1, {3'b000, s_cmd[4:0]});
         end else if (s_cmd[7:4] == 4'b0010) begin
            send_bytes(n, s_addr);
         end else if (!s_cmd[7]) begin           // write with data fields
            for (int i = 0; i < n; i++) begin
               get_bits(9, v);
               s_data[i] = v[8:1];
               s_nbytes++;
               if ($countones(v) % 2 == 0) s_par_ok = 1'b0;
            end
         end
         @(negedge o_sclk);                       // end park bit
         frames++;
      end
   end

   always @(negedge o_sclk) begin
      sclk_falls++;
   end

   // handshake and bus ownership watch
   always @(posedge clk) begin
      if (!rst) begin
         if (o_ack && !ack_q && !i_req) begin
            $display("ack rose without a request");
            hs_err++;
         end
         if (!o_ack && ack_q && i_req) begin
            $display("ack fell while request still high");
            hs_err++;
         end
         if (drv && o_sdata_en) begin
            $display("master drove sdata while the slave was driving");
            hs_err++;
         end
      end
      ack_q <= o_ack;
   end

   ////////////////////
   // host and checks

   function automatic logic [7:0] exp_cmd_byte(input rffe_cmd_pkg::rffe_cmd_t c);
      case (c.kind)
         rffe_cmd_pkg::KIND_REG0_WR: return {1'b1, c.addr[6:0]};
         rffe_cmd_pkg::KIND_REG_WR:  return {3'b010, c.addr[4:0]};
         rffe_cmd_pkg::KIND_REG_RD:  return {3'b011, c.addr[4:0]};
         rffe_cmd_pkg::KIND_EXT_WR:  return {6'b000000, c.bc};
         default:                    return {6'b001000, c.bc};
      endcase
   endfunction

   // sclk cycles in one frame, ssc runs without sclk
   function automatic int frame_sclk_count(input rffe_cmd_pkg::rffe_cmd_t c);
      int n;
      n = 4 + 9 + 1;                              // sa, cmd, end park
      if (c.kind == rffe_cmd_pkg::KIND_EXT_WR || c.kind == rffe_cmd_pkg::KIND_EXT_RD) begin
         n += 9 + 9 * (c.bc + 1);                 // addr and data bytes
      end else if (c.kind != rffe_cmd_pkg::KIND_REG0_WR) begin
         n += 9;
      end
      if (c.kind == rffe_cmd_pkg::KIND_REG_RD || c.kind == rffe_cmd_pkg::KIND_EXT_RD) begin
         n += 1;                                  // park
      end
      return n;
   endfunction

   task automatic compare_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s %s: expected %h, actual %h", tname, what, exp, act);
         test_err++;
      end
   endtask

   initial begin
      rffe_cmd_pkg::rffe_cmd_t c;
      rffe_cmd_pkg::rffe_rsp_t rsp;
      logic [3:0][7:0]         exp_rd;
      int                      nb;
      int                      f0;
      int                      s0;
      hs_err   = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      bad_par  = 1'b0;
      bad_idx  = 0;
      i_req    = 1'b0;
      i_cmd    = '0;
      void'($urandom(32'h8285_db4d));
      for (int i = 0; i < 256; i++) mem[i] = 8'($urandom);
      while (rst) @(posedge clk);
      for (int t = 0; t < NUM_TESTS; t++) begin
         c       = rffe_cmd_pkg::rffe_cmd_t'({$urandom, $urandom});
         c.kind  = rffe_cmd_pkg::rffe_kind_e'($urandom_range(0, 4));
         nb      = (c.kind == rffe_cmd_pkg::KIND_EXT_WR ||
                    c.kind == rffe_cmd_pkg::KIND_EXT_RD) ? c.bc + 1 : 1;
         bad_par = (c.kind == rffe_cmd_pkg::KIND_REG_RD ||
                    c.kind == rffe_cmd_pkg::KIND_EXT_RD) && ($urandom_range(0, 3) == 0);
         bad_idx = $urandom_range(0, nb - 1);
         tname   = $sformatf("test%0d_%s", t, c.kind.name());
         test_err = 0;
         f0       = frames;
         s0       = sclk_falls;
         @(posedge clk);
         i_req <= 1'b1;
         i_cmd <= c;
         do @(posedge clk); while (!o_ack);
         rsp = o_rsp;
         repeat ($urandom_range(0, 20)) @(posedge clk);  // back-pressure hold
         i_req <= 1'b0;
         do @(posedge clk); while (o_ack);
         compare_value("frames", f0 + 1, frames);
         compare_value("sclk cycles", frame_sclk_count(c), sclk_falls - s0);
         compare_value("sa", c.sa, s_sa);
         compare_value("cmd byte", exp_cmd_byte(c), s_cmd);
         compare_value("master parity ok", 1, s_par_ok);
         exp_rd = '0;
         case (c.kind)
            rffe_cmd_pkg::KIND_REG0_WR: compare_value("data bytes", 0, s_nbytes);
            rffe_cmd_pkg::KIND_REG_WR: begin
               compare_value("data bytes", 1, s_nbytes);
               compare_value("data0", c.wdata[0], s_data[0]);
            end
            rffe_cmd_pkg::KIND_EXT_WR: begin
               compare_value("addr", c.addr, s_addr);
               compare_value("data bytes", nb, s_nbytes);
               for (int i = 0; i < nb; i++) compare_value("data", c.wdata[i], s_data[i]);
            end
            default: begin
               if (c.kind == rffe_cmd_pkg::KIND_EXT_RD) begin
                  compare_value("addr", c.addr, s_addr);
                  for (int i = 0; i < nb; i++) exp_rd[i] = mem[8'(c.addr + i)];
               end else begin
                  exp_rd[0] = mem[{3'b000, c.addr[4:0]}];
               end
               compare_value("rdata", exp_rd, rsp.rdata);
               compare_value("perr", bad_par, rsp.perr);
            end
         endcase
         if (test_err == 0) begin
            $display("%s ok", tname);
            pass_cnt++;
         end else begin
            $display("%s had %0d errors", tname, test_err);
            fail_cnt++;
         end
      end
      $display("tests passed %0d, failed %0d, handshake errors %0d", pass_cnt, fail_cnt,
               hs_err + ssc_err);
      if (fail_cnt == 0 && hs_err == 0 && ssc_err == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG);
      $display("timeout, the tests did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: testbench/rffe_sva.sv
// concurrent assertions on the host handshake, bus enable and reset state
module rffe_sva (
   input logic                      clk,
   input logic                      i_rst,
   input logic                      i_req,
   input logic                      o_ack,
   input logic                      i_half,
   input logic                      o_drive,
   input rffe_bus_pkg::rffe_state_e state
);

   // ack drops only once the host has let go of req
   ack_fall_after_req: assert property (@(posedge clk) disable iff (i_rst)
      $fell(o_ack) |-> !$past(i_req))
      else $error("ack fell while req was still high");

   // slave owns the line from mid park on into the data bits
   park_released: assert property (@(posedge clk) disable iff (i_rst)
      ((state == rffe_bus_pkg::ST_PARK && i_half) ||
       $past(state == rffe_bus_pkg::ST_PARK && i_half)) |-> !o_drive)
      else $error("sdata enable high after mid park");

   reset_to_idle: assert property (@(posedge clk)
      i_rst |=> (state == rffe_bus_pkg::ST_IDLE))
      else $error("state not idle after reset");

endmodule

bind rffe_frame_ctrl rffe_sva sva_i (.*);

// File: testbench/tb_clk_gen.sv
// testbench clock and reset source
module tb_clk_gen (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;  // period 8
   end

   initial begin
      o_rst = 1'b1;
      repeat (2) @(posedge o_clk);
      o_rst <= 1'b0;
   end

endmodule

// File: src/rffe_master_top.sv
// bus master top: clock generator, frame sequencer, field shifter, output gating
`include "rffe_consts.svh"

module rffe_master_top #(
   parameter int CLK_DIV = `RFFE_CLK_DIV_DEF
) (
   input  logic                    clk,
   input  logic                    i_rst,
   input  logic                    i_req,
   input  rffe_cmd_pkg::rffe_cmd_t i_cmd,
   output logic                    o_ack,
   output rffe_cmd_pkg::rffe_rsp_t o_rsp,
   input  logic                    i_sdata,
   output logic                    o_sclk,
   output logic                    o_sdata,
   output logic                    o_sdata_en
);

   logic                     tick;
   logic                     half;
   logic                     sclk_phase;
   logic                     load;
   rffe_bus_pkg::rffe_load_t load_data;
   logic                     field_done;
   logic                     perr;
   byte                      rx_byte;
   logic                     tx_bit;
   logic                     ssc;
   logic                     drive;
   logic                     sclk_en;

   rffe_sclk_gen #(
      .CLK_DIV (CLK_DIV)
   ) sclk_gen_i (
      .clk          (clk),
      .i_rst        (i_rst),
      .o_tick       (tick),
      .o_half       (half),
      .o_sclk_phase (sclk_phase)
   );

   rffe_frame_ctrl frame_ctrl_i (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_tick       (tick),
      .i_half       (half),
      .i_req        (i_req),
      .i_cmd        (i_cmd),
      .o_ack        (o_ack),
      .o_rsp        (o_rsp),
      .o_load       (load),
      .o_load_data  (load_data),
      .i_field_done (field_done),
      .i_perr       (perr),
      .i_rx_byte    (rx_byte),
      .o_ssc        (ssc),
      .o_drive      (drive),
      .o_sclk_en    (sclk_en)
   );

   rffe_field_shifter field_shifter_i (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_tick       (tick),
      .i_load       (load),
      .i_load_data  (load_data),
      .i_sdata      (i_sdata),
      .o_bit        (tx_bit),
      .o_field_done (field_done),
      .o_rx_byte    (rx_byte),
      .o_perr       (perr)
   );

   ////////////////////
   // bus pins

   assign o_sclk     = sclk_phase & sclk_en;
   assign o_sdata    = ssc ? 1'b1 : tx_bit;  // ssc high bit, else shifter
   assign o_sdata_en = drive;

endmodule

// File: src/rffe_frame_ctrl.sv
// frame sequencer FSM, command byte build, read collection and host req/ack handshake
`include "rffe_consts.svh"

module rffe_frame_ctrl (
   input  logic                     clk,
   input  logic                     i_rst,
   input  logic                     i_tick,
   input  logic                     i_half,
   input  logic                     i_req,
   input  rffe_cmd_pkg::rffe_cmd_t  i_cmd,
   output logic                     o_ack,
   output rffe_cmd_pkg::rffe_rsp_t  o_rsp,
   output logic                     o_load,
   output rffe_bus_pkg::rffe_load_t o_load_data,
   input  logic                     i_field_done,
   input  logic                     i_perr,
   input  byte                      i_rx_byte,
   output logic                     o_ssc,
   output logic                     o_drive,
   output logic                     o_sclk_en
);

   localparam logic [3:0] NB_PAR = 4'(`RFFE_BYTE_W + 1); // byte plus parity

   rffe_bus_pkg::rffe_state_e state;
   rffe_cmd_pkg::rffe_cmd_t   cmd_q;
   rffe_cmd_pkg::rffe_rsp_t   rsp_q;
   logic [`RFFE_BC_W-1:0]     idx;        // data byte in flight
   logic                      ssc_first;  // high bit of ssc
   logic                      end_bit;    // park bit of END not yet done

   logic                      is_rd;
   logic                      is_ext;
   logic [`RFFE_BC_W-1:0]     last_idx;
   logic [`RFFE_BC_W-1:0]     data_sel;
   logic [`RFFE_BYTE_W-1:0]   cmd_byte;
   rffe_bus_pkg::rffe_load_t  data_ld;

   function automatic rffe_bus_pkg::rffe_load_t mk_load(
      input logic [`RFFE_BYTE_W-1:0] value,
      input logic [3:0]              nbits,
      input logic                    cont,
      input rffe_bus_pkg::rffe_dir_e dir
   );
      rffe_bus_pkg::rffe_load_t ld;
      ld.value = value;
      ld.nbits = nbits;
      ld.cont  = cont;
      ld.dir   = dir;
      return ld;
   endfunction

   ////////////////////
   // command decode

   assign is_rd    = (cmd_q.kind == rffe_cmd_pkg::KIND_REG_RD) ||
                     (cmd_q.kind == rffe_cmd_pkg::KIND_EXT_RD);
   assign is_ext   = (cmd_q.kind == rffe_cmd_pkg::KIND_EXT_WR) ||
                     (cmd_q.kind == rffe_cmd_pkg::KIND_EXT_RD);
   assign last_idx = is_ext ? cmd_q.bc : '0;

   always_comb begin
      case (cmd_q.kind)
         rffe_cmd_pkg::KIND_REG0_WR: cmd_byte = {`RFFE_OP_REG0_WR, cmd_q.addr[6:0]};
         rffe_cmd_pkg::KIND_REG_WR:  cmd_byte = {`RFFE_OP_REG_WR, cmd_q.addr[4:0]};
         rffe_cmd_pkg::KIND_REG_RD:  cmd_byte = {`RFFE_OP_REG_RD, cmd_q.addr[4:0]};
         rffe_cmd_pkg::KIND_EXT_WR:  cmd_byte = {`RFFE_OP_EXT_WR, 2'b00, cmd_q.bc};
         rffe_cmd_pkg::KIND_EXT_RD:  cmd_byte = {`RFFE_OP_EXT_RD, 2'b00, cmd_q.bc};
         default:                    cmd_byte = '0;
      endcase
   end

   // next data field, first byte unless already in DATA
   assign data_sel = (state == rffe_bus_pkg::ST_DATA) ? idx + 1'b1 : '0;
   assign data_ld  = is_rd ? mk_load('0, NB_PAR, 1'b0, rffe_bus_pkg::DIR_IN)
                           : mk_load(cmd_q.wdata[data_sel], NB_PAR, 1'b0, rffe_bus_pkg::DIR_OUT);

   ////////////////////
   // shifter loads, all on a tick

   always_comb begin
      o_load      = 1'b0;
      o_load_data = mk_load('0, 4'd0, 1'b0, rffe_bus_pkg::DIR_OUT);
      case (state)
         rffe_bus_pkg::ST_SSC: begin
            if (i_tick && !ssc_first) begin
               o_load      = 1'b1;
               o_load_data = mk_load({cmd_q.sa, {(`RFFE_BYTE_W - `RFFE_SA_W){1'b0}}},
                                     4'(`RFFE_SA_W), 1'b1, rffe_bus_pkg::DIR_OUT);
            end
         end
         rffe_bus_pkg::ST_SA: begin
            if (i_field_done) begin
               o_load      = 1'b1;
               o_load_data = mk_load(cmd_byte, NB_PAR, 1'b0, rffe_bus_pkg::DIR_OUT);
            end
         end
         rffe_bus_pkg::ST_CMD: begin
            if (i_field_done && is_ext) begin
               o_load      = 1'b1;
               o_load_data = mk_load(cmd_q.addr, NB_PAR, 1'b0, rffe_bus_pkg::DIR_OUT);
            end else if (i_field_done && cmd_q.kind == rffe_cmd_pkg::KIND_REG_WR) begin
               o_load      = 1'b1;
               o_load_data = data_ld;
            end
         end
         rffe_bus_pkg::ST_ADDR: begin
            if (i_field_done && !is_rd) begin
               o_load      = 1'b1;
               o_load_data = data_ld;
            end
         end
         rffe_bus_pkg::ST_PARK: begin
            if (i_tick) begin
               o_load      = 1'b1;
               o_load_data = data_ld;
            end
         end
         rffe_bus_pkg::ST_DATA: begin
            if (i_field_done && idx != last_idx) begin
               o_load      = 1'b1;
               o_load_data = data_ld;
            end
         end
         default: ;
      endcase
   end

   ////////////////////
   // frame FSM and handshake

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state     <= rffe_bus_pkg::ST_IDLE;
         o_ack     <= 1'b0;
         ssc_first <= 1'b0;
         end_bit   <= 1'b0;
         idx       <= '0;
      end else begin
         case (state)
            rffe_bus_pkg::ST_IDLE: begin
               if (i_tick && i_req && !o_ack) begin // start on a bit boundary
                  state     <= rffe_bus_pkg::ST_SSC;
                  ssc_first <= 1'b1;
                  idx       <= '0;
               end
            end
            rffe_bus_pkg::ST_SSC: begin
               if (i_tick) begin
                  if (ssc_first) begin
                     ssc_first <= 1'b0;
                  end else begin
                     state <= rffe_bus_pkg::ST_SA;
                  end
               end
            end
            rffe_bus_pkg::ST_SA: begin
               if (i_field_done) begin
                  state <= rffe_bus_pkg::ST_CMD;
               end
            end
            rffe_bus_pkg::ST_CMD: begin
               if (i_field_done) begin
                  if (is_ext) begin
                     state <= rffe_bus_pkg::ST_ADDR;
                  end else if (cmd_q.kind == rffe_cmd_pkg::KIND_REG0_WR) begin
                     state   <= rffe_bus_pkg::ST_END; // data rode in the cmd byte
                     end_bit <= 1'b1;
                  end else begin
                     state <= is_rd ? rffe_bus_pkg::ST_PARK : rffe_bus_pkg::ST_DATA;
                  end
               end
            end
            rffe_bus_pkg::ST_ADDR: begin
               if (i_field_done) begin
                  state <= is_rd ? rffe_bus_pkg::ST_PARK : rffe_bus_pkg::ST_DATA;
               end
            end
            rffe_bus_pkg::ST_PARK: begin
               if (i_tick) begin
                  state <= rffe_bus_pkg::ST_DATA;
               end
            end
            rffe_bus_pkg::ST_DATA: begin
               if (i_field_done) begin
                  if (idx == last_idx) begin
                     state   <= rffe_bus_pkg::ST_END;
                     end_bit <= 1'b1;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            rffe_bus_pkg::ST_END: begin
               if (end_bit) begin
                  if (i_tick) begin
                     end_bit <= 1'b0;
                     o_ack   <= 1'b1;   // frame over
                  end
               end else if (!i_req) begin
                  o_ack <= 1'b0;
                  state <= rffe_bus_pkg::ST_IDLE;
               end
            end
            default: state <= rffe_bus_pkg::ST_IDLE;
         endcase
      end
   end

   ////////////////////
   // command and response

   always_ff @(posedge clk) begin
      if (state == rffe_bus_pkg::ST_IDLE) begin
         cmd_q <= i_cmd;
         rsp_q <= '0;
      end else if (state == rffe_bus_pkg::ST_DATA && i_field_done && is_rd) begin
         rsp_q.rdata[idx] <= i_rx_byte;
         rsp_q.perr       <= rsp_q.perr | i_perr;
      end
      if (state == rffe_bus_pkg::ST_END && end_bit && i_tick) begin
         o_rsp <= rsp_q; // holds until next ack
      end
   end

   ////////////////////
   // bus control

   assign o_ssc = (state == rffe_bus_pkg::ST_SSC) && ssc_first;

   always_comb begin
      case (state)
         rffe_bus_pkg::ST_SSC,
         rffe_bus_pkg::ST_SA,
         rffe_bus_pkg::ST_CMD,
         rffe_bus_pkg::ST_ADDR: o_drive = 1'b1;
         rffe_bus_pkg::ST_DATA: o_drive = !is_rd;
         rffe_bus_pkg::ST_PARK: o_drive = !i_half;             // drive low, then let go
         rffe_bus_pkg::ST_END:  o_drive = end_bit && !i_half;
         default:               o_drive = 1'b0;
      endcase
   end

   always_comb begin
      case (state)
         rffe_bus_pkg::ST_SA,
         rffe_bus_pkg::ST_CMD,
         rffe_bus_pkg::ST_ADDR,
         rffe_bus_pkg::ST_PARK,
         rffe_bus_pkg::ST_DATA: o_sclk_en = 1'b1;
         rffe_bus_pkg::ST_END:  o_sclk_en = end_bit;   // one park clock only
         default:               o_sclk_en = 1'b0;      // idle and ssc keep sclk low
      endcase
   end

endmodule

// File: src/rffe_field_shifter.sv
// field shift register with odd parity generation and check
`include "rffe_consts.svh"

module rffe_field_shifter (
   input  logic                     clk,
   input  logic                     i_rst,
   input  logic                     i_tick,
   input  logic                     i_load,
   input  rffe_bus_pkg::rffe_load_t i_load_data,
   input  logic                     i_sdata,
   output logic                     o_bit,
   output logic                     o_field_done,
   output byte                      o_rx_byte,
   output logic                     o_perr
);

   localparam int MSB = `RFFE_BYTE_W - 1;

   logic [MSB:0]            sr;
   logic [3:0]              cnt;     // bits left in the field
   logic                    par;     // running xor
   logic                    cont_q;
   rffe_bus_pkg::rffe_dir_e dir_q;

   logic is_par;
   logic step;
   logic cur_bit;
   logic par_upd;

   assign is_par  = (cnt == 4'd1) && !cont_q;                  // last bit of a closed field
   assign step    = i_tick && (cnt != 4'd0);
   assign cur_bit = (dir_q == rffe_bus_pkg::DIR_IN) ? i_sdata : sr[MSB];
   assign par_upd = (step && !is_par) ? (par ^ cur_bit) : par;

   ////////////////////
   // control

   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt    <= 4'd0;
         par    <= 1'b0;
         cont_q <= 1'b0;
         dir_q  <= rffe_bus_pkg::DIR_OUT;
      end else if (i_load) begin
         cnt    <= i_load_data.nbits;
         cont_q <= i_load_data.cont;
         dir_q  <= i_load_data.dir;
         par    <= cont_q ? par_upd : 1'b0;  // sa parity carries into cmd
      end else if (step) begin
         cnt <= cnt - 1'b1;
         par <= par_upd;
      end
   end

   // shift register
   always_ff @(posedge clk) begin
      if (i_load) begin
         sr <= i_load_data.value;
      end else if (step && !is_par) begin
         sr <= {sr[MSB-1:0], (dir_q == rffe_bus_pkg::DIR_IN) ? i_sdata : 1'b0};
      end
   end

   ////////////////////
   // outputs

   always_comb begin
      if (cnt == 4'd0 || dir_q == rffe_bus_pkg::DIR_IN) begin
         o_bit = 1'b0;         // idle or slave driving
      end else if (is_par) begin
         o_bit = ~par;         // make the count of ones odd
      end else begin
         o_bit = sr[MSB];
      end
   end

   assign o_field_done = step && (cnt == 4'd1);
   assign o_rx_byte    = sr;

   // slave parity bit sampled on the closing tick
   assign o_perr = (dir_q == rffe_bus_pkg::DIR_IN) && is_par && !(par ^ i_sdata);

endmodule

// File: src/rffe_sclk_gen.sv
// bit time tick, half bit phase and serial clock phase from clk
`include "rffe_consts.svh"

module rffe_sclk_gen #(
   parameter int CLK_DIV = `RFFE_CLK_DIV_DEF
) (
   input  logic clk,
   input  logic i_rst,
   output logic o_tick,
   output logic o_half,
   output logic o_sclk_phase
);

   localparam int PERIOD = 2 * CLK_DIV;
   localparam int CNT_W  = $clog2(PERIOD);

   logic [CNT_W-1:0] cnt;

   ////////////////////
   // down counter, one bit time per wrap

   always_ff @(posedge clk) begin
      if (i_rst || cnt == '0) begin
         cnt <= CNT_W'(PERIOD - 1);
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // tick ends a bit, everything on the bus moves on it
   assign o_tick = (cnt == '0);

   // upper half of the count is the first half of the bit
   assign o_half       = (cnt < CNT_W'(CLK_DIV));
   assign o_sclk_phase = ~o_half; // high at bit start, low from mid bit

endmodule

// File: src/rffe_bus_pkg.sv
// bus side types: frame state, field direction, shifter load request
`include "rffe_consts.svh"

package rffe_bus_pkg;

   // frame sequencer states
   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,
      ST_SSC  = 3'd1,
      ST_SA   = 3'd2,
      ST_CMD  = 3'd3,
      ST_ADDR = 3'd4,
      ST_PARK = 3'd5,
      ST_DATA = 3'd6,
      ST_END  = 3'd7
   } rffe_state_e;

   typedef enum logic {
      DIR_OUT = 1'b0,
      DIR_IN  = 1'b1
   } rffe_dir_e;

   // one field for the shifter
   // nbits counts the parity bit when one is appended
   typedef struct packed {
      logic [`RFFE_BYTE_W-1:0] value; // msb first
      logic [3:0]              nbits;
      logic                    cont;  // parity runs on into the next field
      rffe_dir_e               dir;
   } rffe_load_t;

endpackage

// File: src/rffe_cmd_pkg.sv
// host side types: frame kind, command struct, response struct
`include "rffe_consts.svh"

package rffe_cmd_pkg;

   ////////////////////
   // frame kinds

   typedef enum logic [2:0] {
      KIND_REG0_WR = 3'd0,
      KIND_REG_WR  = 3'd1,
      KIND_REG_RD  = 3'd2,
      KIND_EXT_WR  = 3'd3,
      KIND_EXT_RD  = 3'd4
   } rffe_kind_e;

   ////////////////////
   // host command, held stable while req is high

   typedef struct packed {
      rffe_kind_e                                     kind;
      logic [`RFFE_SA_W-1:0]                          sa;    // slave address
      logic [`RFFE_BYTE_W-1:0]                        addr;  // reg0 write puts data in [6:0]
      logic [`RFFE_BC_W-1:0]                          bc;    // byte count minus one
      logic [`RFFE_MAX_BYTES-1:0][`RFFE_BYTE_W-1:0]   wdata; // [0] goes out first
   } rffe_cmd_t;

   ////////////////////
   // response, valid from ack rise

   typedef struct packed {
      logic [`RFFE_MAX_BYTES-1:0][`RFFE_BYTE_W-1:0]   rdata; // [0] is first byte read
      logic                                           perr;  // any bad slave parity
   } rffe_rsp_t;

endpackage

// File: src/rffe_consts.svh
// field widths, command opcode patterns, byte count limit, default clock divider
`ifndef RFFE_CONSTS_SVH
`define RFFE_CONSTS_SVH

// field widths
`define RFFE_SA_W        4
`define RFFE_BYTE_W      8
`define RFFE_BC_W        2

// extended frames carry 1 to this many bytes
`define RFFE_MAX_BYTES   4

// clk cycles per half sclk period
`define RFFE_CLK_DIV_DEF 3

// command byte high bits
`define RFFE_OP_REG0_WR  1'b1
`define RFFE_OP_REG_WR   3'b010
`define RFFE_OP_REG_RD   3'b011
`define RFFE_OP_EXT_WR   4'b0000
`define RFFE_OP_EXT_RD   4'b0010

`endif
